/* arp_pkg.sv */
// shared types and constants for the ARP responder
// ARP fields are big-endian on the wire, Ethernet II framing only
`default_nettype none

package arp_pkg;

    // one parsed ARP frame, ethernet header first
    typedef struct packed {
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [7:0]  hlen;
        logic [7:0]  plen;
        logic [15:0] oper;
        logic [47:0] sha;
        logic [31:0] spa;
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_frame_t;

    // ARP header length in payload bytes
    localparam int ARP_HDR_BYTES = 28;
    localparam int ARP_PTR_W     = $clog2(ARP_HDR_BYTES);

    localparam logic [15:0] ARP_ETHERTYPE    = 16'h0806;
    localparam logic [15:0] ARP_HTYPE_ETH    = 16'd1;
    localparam logic [15:0] ARP_PTYPE_IPV4   = 16'h0800;
    localparam logic [7:0]  ARP_HLEN         = 8'd6;
    localparam logic [7:0]  ARP_PLEN         = 8'd4;
    localparam logic [15:0] ARP_OPER_REQUEST = 16'd1;
    localparam logic [15:0] ARP_OPER_REPLY   = 16'd2;

    // APB register map
    localparam int APB_AW = 8;
    localparam int CNT_W  = 16;

    localparam logic [APB_AW-1:0] REG_CTRL      = 8'h00;
    localparam logic [APB_AW-1:0] REG_MAC_LO    = 8'h04;
    localparam logic [APB_AW-1:0] REG_MAC_HI    = 8'h08;
    localparam logic [APB_AW-1:0] REG_IP        = 8'h0C;
    localparam logic [APB_AW-1:0] REG_REPLY_CNT = 8'h10;
    localparam logic [APB_AW-1:0] REG_ERR_CNT   = 8'h14;
    localparam logic [APB_AW-1:0] REG_DROP_CNT  = 8'h18;

endpackage

`default_nettype wire

/* arp_frame_if.sv */
// parsed ARP frame from receiver to reply generator
// error pulses are single cycle and ignore ready
`timescale 1ns/1ps
`default_nettype none

interface arp_frame_if
    import arp_pkg::*;
();

    logic       valid;
    logic       ready;
    arp_frame_t frame;
    // status pulses, also tapped at the top level
    logic       err_early;
    logic       err_invalid;

    modport rx (
        output valid,
        output frame,
        output err_early,
        output err_invalid,
        input  ready
    );

    modport gen (
        input  valid,
        input  frame,
        output ready
    );

endinterface

`default_nettype wire

/* arp_cfg_if.sv */
// configuration from register block, event pulses back to it
`timescale 1ns/1ps
`default_nettype none

interface arp_cfg_if;

    logic [47:0] local_mac;
    logic [31:0] local_ip;
    logic        enable;
    // one cycle event pulses
    logic        reply_sent;
    logic        frame_dropped;

    modport regs (
        output local_mac,
        output local_ip,
        output enable,
        input  reply_sent,
        input  frame_dropped
    );

    modport gen (
        input  local_mac,
        input  local_ip,
        input  enable,
        output reply_sent,
        output frame_dropped
    );

endinterface

`default_nettype wire

/* arp_rx_parser.sv */
// decodes the 28 ARP header bytes of each frame, bytes past 28 are discarded
// holds one parsed frame, no new header is taken while it waits
`timescale 1ns/1ps
`default_nettype none

module arp_rx_parser
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        eth_hdr_valid,
    output logic        eth_hdr_ready,
    input  logic [47:0] eth_dest_mac,
    input  logic [47:0] eth_src_mac,
    input  logic [15:0] eth_type,
    input  logic [7:0]  eth_tdata,
    input  logic        eth_tvalid,
    input  logic        eth_tlast,
    input  logic        eth_tuser,
    output logic        eth_tready,

    arp_frame_if.rx     out
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_HDR,
        ST_WAIT_LAST
    } state_t;

    state_t               state_q;
    state_t               state_d;
    logic [ARP_PTR_W-1:0] ptr_q;
    logic [ARP_PTR_W-1:0] ptr_d;
    logic                 hdr_ready_q;
    logic                 hdr_ready_d;
    logic                 tready_q;
    logic                 tready_d;
    logic                 valid_q;
    logic                 valid_d;
    logic                 err_early_q;
    logic                 err_early_d;
    logic                 err_invalid_q;
    logic                 err_invalid_d;
    logic                 store_hdr;
    logic                 store_byte;
    logic                 byte_xfer;
    logic                 lengths_ok;
    arp_frame_t           frame_q;

    assign byte_xfer  = eth_tvalid && tready_q;
    assign lengths_ok = (frame_q.hlen == ARP_HLEN) && (frame_q.plen == ARP_PLEN);

    always_comb begin
        state_d       = state_q;
        ptr_d         = ptr_q;
        hdr_ready_d   = 1'b0;
        tready_d      = 1'b0;
        valid_d       = valid_q && !out.ready;
        err_early_d   = 1'b0;
        err_invalid_d = 1'b0;
        store_hdr     = 1'b0;
        store_byte    = 1'b0;

        case (state_q)
            ST_IDLE: begin
                ptr_d       = '0;
                hdr_ready_d = !valid_d;
                if (hdr_ready_q && eth_hdr_valid) begin
                    hdr_ready_d = 1'b0;
                    tready_d    = 1'b1;
                    store_hdr   = 1'b1;
                    state_d     = ST_READ_HDR;
                end
            end
            ST_READ_HDR: begin
                tready_d = 1'b1;
                if (byte_xfer) begin
                    store_byte = 1'b1;
                    ptr_d      = ptr_q + 1'b1;
                    if (ptr_q == ARP_PTR_W'(ARP_HDR_BYTES - 1)) begin
                        state_d = ST_WAIT_LAST;
                    end
                    if (eth_tlast) begin
                        // header cut short
                        if (ptr_q != ARP_PTR_W'(ARP_HDR_BYTES - 1)) begin
                            err_early_d = 1'b1;
                        end else if (!lengths_ok) begin
                            err_invalid_d = 1'b1;
                        end else begin
                            valid_d = !eth_tuser;
                        end
                        tready_d    = 1'b0;
                        hdr_ready_d = !valid_d;
                        state_d     = ST_IDLE;
                    end
                end
            end
            ST_WAIT_LAST: begin
                // drain padding until tlast
                tready_d = 1'b1;
                if (byte_xfer && eth_tlast) begin
                    if (!lengths_ok) begin
                        err_invalid_d = 1'b1;
                    end else begin
                        valid_d = !eth_tuser;
                    end
                    tready_d    = 1'b0;
                    hdr_ready_d = !valid_d;
                    state_d     = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= ST_IDLE;
            ptr_q         <= '0;
            hdr_ready_q   <= 1'b0;
            tready_q      <= 1'b0;
            valid_q       <= 1'b0;
            err_early_q   <= 1'b0;
            err_invalid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            ptr_q         <= ptr_d;
            hdr_ready_q   <= hdr_ready_d;
            tready_q      <= tready_d;
            valid_q       <= valid_d;
            err_early_q   <= err_early_d;
            err_invalid_q <= err_invalid_d;
        end
    end

    // frame payload, first ARP byte lands in the top of htype
    always_ff @(posedge clk) begin
        if (store_hdr) begin
            frame_q.eth_dest_mac <= eth_dest_mac;
            frame_q.eth_src_mac  <= eth_src_mac;
            frame_q.eth_type     <= eth_type;
        end
        if (store_byte) begin
            frame_q[(ARP_HDR_BYTES - 1 - int'(ptr_q)) * 8 +: 8] <= eth_tdata;
        end
    end

    assign eth_hdr_ready   = hdr_ready_q;
    assign eth_tready      = tready_q;
    assign out.valid       = valid_q;
    assign out.frame       = frame_q;
    assign out.err_early   = err_early_q;
    assign out.err_invalid = err_invalid_q;

    // a stalled frame must not be overwritten by the next header
    a_frame_held: assert property (@(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> out.valid && $stable(out.frame));

endmodule

`default_nettype wire

/* arp_apb_regs.sv */
// zero wait state APB slave, counters are read-only and wrap
`timescale 1ns/1ps
`default_nettype none

module arp_apb_regs
    import arp_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,

    input  logic              err_early,
    input  logic              err_invalid,

    arp_cfg_if.regs           cfg
);

    logic             enable_q;
    logic [47:0]      mac_q;
    logic [31:0]      ip_q;
    logic [CNT_W-1:0] reply_cnt_q;
    logic [CNT_W-1:0] err_cnt_q;
    logic [CNT_W-1:0] drop_cnt_q;
    logic             access;
    logic             mapped;
    logic             read_only;
    logic             wr_en;

    assign access = psel && penable;

    // address decode and read mux
    always_comb begin
        prdata    = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr)
            REG_CTRL:   prdata = {31'b0, enable_q};
            REG_MAC_LO: prdata = mac_q[31:0];
            REG_MAC_HI: prdata = {16'b0, mac_q[47:32]};
            REG_IP:     prdata = ip_q;
            REG_REPLY_CNT: begin
                prdata    = {{(32 - CNT_W){1'b0}}, reply_cnt_q};
                read_only = 1'b1;
            end
            REG_ERR_CNT: begin
                prdata    = {{(32 - CNT_W){1'b0}}, err_cnt_q};
                read_only = 1'b1;
            end
            REG_DROP_CNT: begin
                prdata    = {{(32 - CNT_W){1'b0}}, drop_cnt_q};
                read_only = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    assign wr_en   = access && pwrite && mapped && !read_only;
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && read_only));

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q    <= 1'b0;
            mac_q       <= '0;
            ip_q        <= '0;
            reply_cnt_q <= '0;
            err_cnt_q   <= '0;
            drop_cnt_q  <= '0;
        end else begin
            if (wr_en && paddr == REG_CTRL)   enable_q     <= pwdata[0];
            if (wr_en && paddr == REG_MAC_LO) mac_q[31:0]  <= pwdata;
            if (wr_en && paddr == REG_MAC_HI) mac_q[47:32] <= pwdata[15:0];
            if (wr_en && paddr == REG_IP)     ip_q         <= pwdata;
            reply_cnt_q <= reply_cnt_q + CNT_W'(cfg.reply_sent);
            // both error kinds share one counter
            err_cnt_q   <= err_cnt_q + CNT_W'(err_early) + CNT_W'(err_invalid);
            drop_cnt_q  <= drop_cnt_q + CNT_W'(cfg.frame_dropped);
        end
    end

    assign cfg.enable    = enable_q;
    assign cfg.local_mac = mac_q;
    assign cfg.local_ip  = ip_q;

    a_penable_in_sel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel);

endmodule

`default_nettype wire

/* arp_reply_gen.sv */
// answers enabled ARP requests for the local IP, drops everything else
// one reply register, refilled in the cycle it drains
`timescale 1ns/1ps
`default_nettype none

module arp_reply_gen
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    arp_frame_if.gen    in,
    arp_cfg_if.gen      cfg,

    output logic        reply_valid,
    input  logic        reply_ready,
    output logic [47:0] reply_dest_mac,
    output logic [47:0] reply_src_mac,
    output logic [31:0] reply_spa,
    output logic [31:0] reply_tpa
);

    logic        valid_q;
    logic        dropped_q;
    logic        accept;
    logic        match;
    logic [47:0] dest_mac_q;
    logic [47:0] src_mac_q;
    logic [31:0] spa_q;
    logic [31:0] tpa_q;

    assign in.ready = !valid_q || reply_ready;
    assign accept   = in.valid && in.ready;

    assign match = cfg.enable
                && in.frame.htype == ARP_HTYPE_ETH
                && in.frame.ptype == ARP_PTYPE_IPV4
                && in.frame.oper == ARP_OPER_REQUEST
                && in.frame.tpa == cfg.local_ip;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            dropped_q <= 1'b0;
        end else begin
            dropped_q <= accept && !match;
            if (accept && match) begin
                valid_q <= 1'b1;
            end else if (reply_ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    // reply fields, swapped around from the request
    always_ff @(posedge clk) begin
        if (accept && match) begin
            dest_mac_q <= in.frame.sha;
            src_mac_q  <= cfg.local_mac;
            spa_q      <= cfg.local_ip;
            tpa_q      <= in.frame.spa;
        end
    end

    assign reply_valid       = valid_q;
    assign reply_dest_mac    = dest_mac_q;
    assign reply_src_mac     = src_mac_q;
    assign reply_spa         = spa_q;
    assign reply_tpa         = tpa_q;
    assign cfg.reply_sent    = valid_q && reply_ready;
    assign cfg.frame_dropped = dropped_q;

    a_reply_held: assert property (@(posedge clk) disable iff (rst)
        reply_valid && !reply_ready |=> reply_valid
            && $stable({reply_dest_mac, reply_src_mac, reply_spa, reply_tpa}));

endmodule

`default_nettype wire

/* arp_top.sv */
// ARP responder: receiver, APB registers and reply generator
// reply carries only the varying fields, oper is always a reply
`timescale 1ns/1ps
`default_nettype none

module arp_top
    import arp_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // ethernet receive
    input  logic              eth_hdr_valid,
    output logic              eth_hdr_ready,
    input  logic [47:0]       eth_dest_mac,
    input  logic [47:0]       eth_src_mac,
    input  logic [15:0]       eth_type,
    input  logic [7:0]        eth_tdata,
    input  logic              eth_tvalid,
    input  logic              eth_tlast,
    input  logic              eth_tuser,
    output logic              eth_tready,

    // APB configuration
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,

    // reply fields
    output logic              reply_valid,
    input  logic              reply_ready,
    output logic [47:0]       reply_dest_mac,
    output logic [47:0]       reply_src_mac,
    output logic [31:0]       reply_spa,
    output logic [31:0]       reply_tpa
);

    arp_frame_if frame_if ();
    arp_cfg_if   cfg_if ();

    arp_rx_parser u_rx (
        .clk           (clk),
        .rst           (rst),
        .eth_hdr_valid (eth_hdr_valid),
        .eth_hdr_ready (eth_hdr_ready),
        .eth_dest_mac  (eth_dest_mac),
        .eth_src_mac   (eth_src_mac),
        .eth_type      (eth_type),
        .eth_tdata     (eth_tdata),
        .eth_tvalid    (eth_tvalid),
        .eth_tlast     (eth_tlast),
        .eth_tuser     (eth_tuser),
        .eth_tready    (eth_tready),
        .out           (frame_if.rx)
    );

    // error pulses are tapped straight off the frame interface
    arp_apb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .err_early   (frame_if.err_early),
        .err_invalid (frame_if.err_invalid),
        .cfg         (cfg_if.regs)
    );

    arp_reply_gen u_gen (
        .clk            (clk),
        .rst            (rst),
        .in             (frame_if.gen),
        .cfg            (cfg_if.gen),
        .reply_valid    (reply_valid),
        .reply_ready    (reply_ready),
        .reply_dest_mac (reply_dest_mac),
        .reply_src_mac  (reply_src_mac),
        .reply_spa      (reply_spa),
        .reply_tpa      (reply_tpa)
    );

endmodule

`default_nettype wire

/* tb_arp_top.sv */
// self-checking testbench for the ARP responder, LFSR stimulus from a fixed seed
// replies are checked in order against a model queue, counters at the end of the run
`timescale 1ns/1ps
`default_nettype none

module tb_arp_top
    import arp_pkg::*;
();

    localparam int          WAIT_MAX = 500;
    localparam logic [31:0] SEED     = 32'h908b_056b;

    logic              clk;
    logic              rst;
    logic              eth_hdr_valid;
    logic              eth_hdr_ready;
    logic [47:0]       eth_dest_mac;
    logic [47:0]       eth_src_mac;
    logic [15:0]       eth_type;
    logic [7:0]        eth_tdata;
    logic              eth_tvalid;
    logic              eth_tlast;
    logic              eth_tuser;
    logic              eth_tready;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              reply_valid;
    logic              reply_ready;
    logic [47:0]       reply_dest_mac;
    logic [47:0]       reply_src_mac;
    logic [31:0]       reply_spa;
    logic [31:0]       reply_tpa;

    // model state
    logic [31:0]      rng;
    logic [31:0]      stall_rng = SEED;
    logic             stall_bit;
    logic [159:0]     exp_q[$];
    logic [159:0]     exp_reply;
    logic             model_en;
    logic [47:0]      model_mac;
    logic [31:0]      model_ip;
    logic [CNT_W-1:0] model_replies;
    logic [CNT_W-1:0] model_errs;
    logic [CNT_W-1:0] model_drops;

    arp_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);
            v   = {v[30:0], rng[0]};
        end
        return v;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_reply(input logic [47:0] dest_mac, input logic [47:0] src_mac,
                               input logic [31:0] spa, input logic [31:0] tpa,
                               input logic [159:0] exp);
        if ({dest_mac, src_mac, spa, tpa} !== exp) begin
            report_failure($sformatf(
                "MISMATCH at %0t: reply got %h %h %h %h expected %h %h %h %h", $time,
                dest_mac, src_mac, spa, tpa, exp[159:112], exp[111:64], exp[63:32], exp[31:0]));
        end
    endtask

    // one APB transfer, setup phase then access phase until pready
    task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] rdata);
        int cnt;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        cnt = 0;
        @(posedge clk);
        while (!pready) begin
            cnt++;
            if (cnt == WAIT_MAX) begin
                report_failure("timeout waiting for pready");
            end
            @(posedge clk);
        end
        rdata = prdata;
        check_word($sformatf("pslverr at %h", addr), {31'b0, pslverr}, {31'b0, exp_err});
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
                            input logic exp_err);
        logic [31:0] rd;
        apb_transfer(1'b0, addr, 32'h0, exp_err, rd);
        if (!exp_err) begin
            check_word($sformatf("register %h", addr), rd, exp);
        end
    endtask

    // header, then the ARP bytes and random padding, with random tvalid gaps
    task automatic send_frame(input logic [223:0] arp_hdr, input logic [47:0] src_mac,
                              input int nbytes, input logic tuser, output logic free);
        logic [31:0] w;
        logic [7:0]  b;
        int          cnt;
        eth_hdr_valid <= 1'b1;
        eth_dest_mac  <= '1;
        eth_src_mac   <= src_mac;
        eth_type      <= ARP_ETHERTYPE;
        cnt = 0;
        @(posedge clk);
        while (!eth_hdr_ready) begin
            cnt++;
            if (cnt == WAIT_MAX) begin
                report_failure("timeout waiting for eth_hdr_ready");
            end
            @(posedge clk);
        end
        eth_hdr_valid <= 1'b0;
        free = 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            if (i < ARP_HDR_BYTES) begin
                b = arp_hdr[223 - 8 * i -: 8];
            end else begin
                w = rand_bits(8);
                b = w[7:0];
            end
            if (rand_bits(2) == 32'd0) begin
                eth_tvalid <= 1'b0;
                @(posedge clk);
            end
            eth_tdata  <= b;
            eth_tvalid <= 1'b1;
            eth_tlast  <= (i == nbytes - 1);
            eth_tuser  <= tuser && (i == nbytes - 1);
            cnt = 0;
            @(posedge clk);
            while (!eth_tready) begin
                cnt++;
                if (cnt == WAIT_MAX) begin
                    report_failure("timeout waiting for eth_tready");
                end
                @(posedge clk);
            end
            free = !reply_valid;
        end
        eth_tvalid <= 1'b0;
        eth_tlast  <= 1'b0;
        eth_tuser  <= 1'b0;
    endtask

    // one frame with random addresses, outcome predicted from the ARP rules
    task automatic send_arp(input logic [15:0] htype, input logic [15:0] ptype,
                            input logic [7:0] hlen, input logic [7:0] plen,
                            input logic [15:0] oper, input logic [31:0] tpa,
                            input int nbytes, input logic tuser);
        logic [31:0] w;
        logic [47:0] sha;
        logic [47:0] tha;
        logic [31:0] spa;
        logic        free;
        logic        answer;
        w      = rand_bits(16);
        sha    = {w[15:0], rand_bits(32)};
        w      = rand_bits(16);
        tha    = {w[15:0], rand_bits(32)};
        spa    = rand_bits(32);
        answer = 1'b0;
        send_frame({htype, ptype, hlen, plen, oper, sha, spa, tha, tpa}, sha, nbytes, tuser,
                   free);
        if (nbytes < ARP_HDR_BYTES || hlen != ARP_HLEN || plen != ARP_PLEN) begin
            model_errs++;
        end else if (!tuser) begin
            if (model_en && htype == ARP_HTYPE_ETH && ptype == ARP_PTYPE_IPV4
                    && oper == ARP_OPER_REQUEST && tpa == model_ip) begin
                exp_q.push_back({sha, model_mac, model_ip, spa});
                model_replies++;
                answer = 1'b1;
            end else begin
                model_drops++;
            end
        end
        // free path, so reply_valid must rise exactly two cycles after tlast
        if (answer && free) begin
            @(posedge clk);
            if (reply_valid) begin
                report_failure($sformatf("MISMATCH at %0t: reply_valid one cycle after tlast",
                                         $time));
            end
            @(posedge clk);
            if (!reply_valid) begin
                report_failure($sformatf("MISMATCH at %0t: no reply two cycles after tlast",
                                         $time));
            end
        end
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            cnt++;
            if (cnt == WAIT_MAX) begin
                report_failure("timeout waiting for the expected replies");
            end
            @(posedge clk);
        end
        // drop pulse and counter update trail tlast by three cycles
        repeat (4) @(posedge clk);
    endtask

    // reply sink with random stalls, about one cycle in four
    always @(posedge clk) begin
        if (rst) begin
            reply_ready <= 1'b0;
        end else begin
            if (reply_valid && reply_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("a reply came out with no request pending");
                end else begin
                    exp_reply = exp_q.pop_front();
                    check_reply(reply_dest_mac, reply_src_mac, reply_spa, reply_tpa,
                                exp_reply);
                end
            end
            stall_rng   = lfsr_step(stall_rng);
            stall_bit   = stall_rng[0];
            stall_rng   = lfsr_step(stall_rng);
            reply_ready <= stall_bit | stall_rng[0];
        end
    end

    initial begin
        int          kind;
        int          pad;
        logic [31:0] w;
        rng           = SEED;
        rst           = 1'b1;
        eth_hdr_valid = 1'b0;
        eth_dest_mac  = '0;
        eth_src_mac   = '0;
        eth_type      = '0;
        eth_tdata     = '0;
        eth_tvalid    = 1'b0;
        eth_tlast     = 1'b0;
        eth_tuser     = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        reply_ready   = 1'b0;
        model_replies = '0;
        model_errs    = '0;
        model_drops   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // register access, upper MAC_HI bits are not stored
        w         = rand_bits(32);
        model_mac = {w[15:0], rand_bits(32)};
        model_ip  = rand_bits(32);
        model_en  = 1'b1;
        apb_write(REG_CTRL, 32'h0000_0003, 1'b0);
        apb_write(REG_MAC_LO, model_mac[31:0], 1'b0);
        apb_write(REG_MAC_HI, w, 1'b0);
        apb_write(REG_IP, model_ip, 1'b0);
        apb_read(REG_CTRL, 32'h0000_0001, 1'b0);
        apb_read(REG_MAC_LO, model_mac[31:0], 1'b0);
        apb_read(REG_MAC_HI, {16'h0, model_mac[47:32]}, 1'b0);
        apb_read(REG_IP, model_ip, 1'b0);
        apb_write(REG_REPLY_CNT, 32'h0000_0005, 1'b1);
        apb_write(REG_DROP_CNT, 32'h0000_0007, 1'b1);
        apb_write(8'h1C, 32'h0000_0001, 1'b1);
        apb_read(8'h20, 32'h0, 1'b1);
        apb_read(REG_REPLY_CNT, 32'h0, 1'b0);

        for (int f = 0; f < 80; f++) begin
            kind = rand_bits(3);
            pad  = rand_bits(2);
            w    = rand_bits(32);
            case (kind)
                0, 1: send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN,
                               ARP_OPER_REQUEST, model_ip, ARP_HDR_BYTES + pad, 1'b0);
                2: send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN,
                            ARP_OPER_REQUEST, model_ip ^ (w | 32'd1), ARP_HDR_BYTES + pad, 1'b0);
                3: send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN,
                            ARP_OPER_REPLY, model_ip, ARP_HDR_BYTES + pad, 1'b0);
                4: send_arp(w[31] ? 16'h0006 : ARP_HTYPE_ETH, w[31] ? ARP_PTYPE_IPV4 : 16'h86DD,
                            ARP_HLEN, ARP_PLEN, ARP_OPER_REQUEST, model_ip,
                            ARP_HDR_BYTES + pad, 1'b0);
                5: send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN,
                            ARP_OPER_REQUEST, model_ip, int'(w[4:0]) % 27 + 1, 1'b0);
                6: send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, w[0] ? 8'd8 : ARP_HLEN,
                            w[0] ? ARP_PLEN : 8'd16, ARP_OPER_REQUEST, model_ip,
                            ARP_HDR_BYTES + pad, 1'b0);
                default: send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN,
                                  ARP_OPER_REQUEST, model_ip, ARP_HDR_BYTES + pad, 1'b1);
            endcase
        end

        // requests while disabled are dropped
        drain();
        apb_write(REG_CTRL, 32'h0, 1'b0);
        model_en = 1'b0;
        for (int f = 0; f < 4; f++) begin
            send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN, ARP_OPER_REQUEST,
                     model_ip, ARP_HDR_BYTES + f, 1'b0);
        end
        drain();
        apb_write(REG_CTRL, 32'h1, 1'b0);
        model_en = 1'b1;
        send_arp(ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN, ARP_OPER_REQUEST,
                 model_ip, ARP_HDR_BYTES + 3, 1'b0);
        drain();

        apb_read(REG_REPLY_CNT, 32'(model_replies), 1'b0);
        apb_read(REG_ERR_CNT, 32'(model_errs), 1'b0);
        apb_read(REG_DROP_CNT, 32'(model_drops), 1'b0);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
arp_pkg.sv
arp_frame_if.sv
arp_cfg_if.sv
arp_rx_parser.sv
arp_apb_regs.sv
arp_reply_gen.sv
arp_top.sv
tb_arp_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_arp_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, the simulator status alone is not trusted
run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
